// ==== hw/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

    localparam int regAddrW = 5;   // register number width
    localparam int dataW = 32;     // data word width
    localparam int numRegs = 32;

    // forwarding select for the decode operands
    // higher code means a younger producing stage
    typedef enum logic [2:0] {
        fwdNone = 3'b000,  // take the register file value
        fwdW    = 3'b001,
        fwdM2   = 3'b010,
        fwdM    = 3'b011,
        fwdE    = 3'b100
    } fwdSel;

    // what a decoded instruction does with its destination
    typedef enum logic [1:0] {
        kAlu  = 2'd0,  // result ready in E
        kLoad = 2'd1,  // data back from M2 on
        kMfc  = 2'd2,  // cp0 read, late result
        kHilo = 2'd3   // hi/lo read, late result
    } instKind;

endpackage

// ==== hw/hazard.sv ====
`timescale 1ns/1ps

module hazard (
    input  logic iCacheStall,
    input  logic dCacheStall,
    input  logic aluStallE,
    input  logic flushJumpConflictE,
    input  logic flushPredFailedM,
    input  logic flushExceptionM,
    input  logic jumpD,
    input  logic isMfcE,       // cp0 read in E
    input  logic hiloToRegE,   // hi/lo read in E
    input  logic memReadE,     // load in E
    input  logic memReadM,     // load in M
    input  logic [pipeCtrlPkg::regAddrW-1:0] rsD,
    input  logic [pipeCtrlPkg::regAddrW-1:0] rtD,
    input  logic regWriteE,
    input  logic regWriteM,
    input  logic regWriteM2,
    input  logic regWriteW,
    input  logic [pipeCtrlPkg::regAddrW-1:0] writeRegE,
    input  logic [pipeCtrlPkg::regAddrW-1:0] writeRegM,
    input  logic [pipeCtrlPkg::regAddrW-1:0] writeRegM2,
    input  logic [pipeCtrlPkg::regAddrW-1:0] writeRegW,
    output logic stallF,
    output logic stallF2,
    output logic stallD,
    output logic stallE,
    output logic stallM,
    output logic stallM2,
    output logic stallW,
    output logic flushF,
    output logic flushF2,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushM2,
    output logic flushW,
    output logic longestStall,
    output logic stallDBlank,
    output pipeCtrlPkg::fwdSel forward1D,
    output pipeCtrlPkg::fwdSel forward2D
);
    import pipeCtrlPkg::*;

    logic cacheStall;
    logic loadUseE;
    logic loadUseM;

    // youngest matching writer wins, r0 never forwards
    function automatic fwdSel pickSrc(
        input logic [regAddrW-1:0] src,
        input logic                wrE,
        input logic                wrM,
        input logic                wrM2,
        input logic                wrW,
        input logic [regAddrW-1:0] dstE,
        input logic [regAddrW-1:0] dstM,
        input logic [regAddrW-1:0] dstM2,
        input logic [regAddrW-1:0] dstW
    );
        fwdSel sel;
        sel = fwdNone;
        if (src != '0) begin
            if (wrE && src == dstE) sel = fwdE;
            else if (wrM && src == dstM) sel = fwdM;
            else if (wrM2 && src == dstM2) sel = fwdM2;
            else if (wrW && src == dstW) sel = fwdW;
        end
        return sel;
    endfunction

    assign forward1D = pickSrc(rsD, regWriteE, regWriteM, regWriteM2, regWriteW,
                               writeRegE, writeRegM, writeRegM2, writeRegW);
    assign forward2D = pickSrc(rtD, regWriteE, regWriteM, regWriteM2, regWriteW,
                               writeRegE, writeRegM, writeRegM2, writeRegW);

    // results that are not ready when the consumer sits in D
    assign loadUseE = (forward1D == fwdE || forward2D == fwdE)
                      && (memReadE || isMfcE || hiloToRegE);
    assign loadUseM = (forward1D == fwdM || forward2D == fwdM) && memReadM;
    assign stallDBlank = (loadUseE || loadUseM) && !flushExceptionM;

    assign cacheStall   = iCacheStall | dCacheStall;
    assign longestStall = cacheStall | aluStallE;

    // front end keeps going when an exception redirects it
    assign stallF  = !flushExceptionM && (longestStall || stallDBlank);
    assign stallF2 = !flushExceptionM && (longestStall || stallDBlank);
    assign stallD  = longestStall | stallDBlank;
    assign stallE  = longestStall;
    assign stallM  = longestStall;
    assign stallM2 = longestStall;
    assign stallW  = !flushExceptionM && longestStall;  // W drains on an exception

    assign flushF  = 1'b0;
    assign flushF2 = flushExceptionM | flushPredFailedM
                     | ((flushJumpConflictE | jumpD) & ~stallF2);
    assign flushD  = flushExceptionM | flushPredFailedM | (flushJumpConflictE & ~stallD);
    // bubble into E while D waits on a late result
    assign flushE  = flushExceptionM | (flushPredFailedM & ~longestStall)
                     | (~stallE & stallDBlank);
    assign flushM  = flushExceptionM;
    assign flushM2 = flushExceptionM;
    assign flushW  = flushExceptionM;

endmodule

// ==== hw/destTrack.sv ====
`timescale 1ns/1ps

module destTrack (
    input  logic clk,
    input  logic rstN,
    input  logic [pipeCtrlPkg::regAddrW-1:0] writeRegD,
    input  logic regWriteD,
    input  pipeCtrlPkg::instKind kindD,
    input  logic [pipeCtrlPkg::dataW-1:0] resultD,
    input  logic stallD,
    input  logic stallE,
    input  logic stallM,
    input  logic stallM2,
    input  logic stallW,
    input  logic flushE,
    input  logic flushM,
    input  logic flushM2,
    input  logic flushW,
    output logic regWriteE,
    output logic regWriteM,
    output logic regWriteM2,
    output logic regWriteW,
    output logic [pipeCtrlPkg::regAddrW-1:0] writeRegE,
    output logic [pipeCtrlPkg::regAddrW-1:0] writeRegM,
    output logic [pipeCtrlPkg::regAddrW-1:0] writeRegM2,
    output logic [pipeCtrlPkg::regAddrW-1:0] writeRegW,
    output logic [pipeCtrlPkg::dataW-1:0] resultE,
    output logic [pipeCtrlPkg::dataW-1:0] resultM,
    output logic [pipeCtrlPkg::dataW-1:0] resultM2,
    output logic [pipeCtrlPkg::dataW-1:0] resultW,
    output logic memReadE,
    output logic memReadM,
    output logic isMfcE,
    output logic hiloToRegE
);
    import pipeCtrlPkg::*;

    instKind kindE;
    instKind kindM;  // kind is only needed up to M

    // valid bits, flush beats stall in every stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteE  <= 1'b0;
            regWriteM  <= 1'b0;
            regWriteM2 <= 1'b0;
            regWriteW  <= 1'b0;
        end else begin
            if (flushE) regWriteE <= 1'b0;
            else if (!stallE) regWriteE <= regWriteD && !stallD;  // held D enters as bubble

            if (flushM) regWriteM <= 1'b0;
            else if (!stallM) regWriteM <= regWriteE;

            if (flushM2) regWriteM2 <= 1'b0;
            else if (!stallM2) regWriteM2 <= regWriteM;

            if (flushW) regWriteW <= 1'b0;
            else if (!stallW) regWriteW <= regWriteM2;
        end
    end

    // payload follows the stall only, a bubble is marked by its valid bit
    always_ff @(posedge clk) begin
        if (!stallE) begin
            writeRegE <= writeRegD;
            kindE     <= kindD;
            resultE   <= resultD;
        end
        if (!stallM) begin
            writeRegM <= writeRegE;
            kindM     <= kindE;
            resultM   <= resultE;
        end
        if (!stallM2) begin
            writeRegM2 <= writeRegM;
            resultM2   <= resultM;
        end
        if (!stallW) begin
            writeRegW <= writeRegM2;
            resultW   <= resultM2;
        end
    end

    // late-result flags for the hazard unit
    assign memReadE   = regWriteE && kindE == kLoad;
    assign isMfcE     = regWriteE && kindE == kMfc;
    assign hiloToRegE = regWriteE && kindE == kHilo;
    assign memReadM   = regWriteM && kindM == kLoad;

    bubbleE: assert property (@(posedge clk) disable iff (!rstN) flushE |=> !regWriteE)
        else $error("destTrack: flushed E still writes");
    bubbleM: assert property (@(posedge clk) disable iff (!rstN) flushM |=> !regWriteM)
        else $error("destTrack: flushed M still writes");
    bubbleM2: assert property (@(posedge clk) disable iff (!rstN) flushM2 |=> !regWriteM2)
        else $error("destTrack: flushed M2 still writes");
    bubbleW: assert property (@(posedge clk) disable iff (!rstN) flushW |=> !regWriteW)
        else $error("destTrack: flushed W still writes");

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic rstN,
    input  logic we,
    input  logic [pipeCtrlPkg::regAddrW-1:0] waddr,
    input  logic [pipeCtrlPkg::dataW-1:0] wdata,
    input  logic [pipeCtrlPkg::regAddrW-1:0] raddr1,
    input  logic [pipeCtrlPkg::regAddrW-1:0] raddr2,
    output logic [pipeCtrlPkg::dataW-1:0] rdata1,
    output logic [pipeCtrlPkg::dataW-1:0] rdata2
);
    import pipeCtrlPkg::*;

    logic [dataW-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // r0 is never written
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read, no internal write-through
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/operandBypass.sv ====
`timescale 1ns/1ps

module operandBypass (
    input  pipeCtrlPkg::fwdSel forward1D,
    input  pipeCtrlPkg::fwdSel forward2D,
    input  logic [pipeCtrlPkg::dataW-1:0] rfData1,
    input  logic [pipeCtrlPkg::dataW-1:0] rfData2,
    input  logic [pipeCtrlPkg::dataW-1:0] resultE,
    input  logic [pipeCtrlPkg::dataW-1:0] resultM,
    input  logic [pipeCtrlPkg::dataW-1:0] resultM2,
    input  logic [pipeCtrlPkg::dataW-1:0] resultW,
    output logic [pipeCtrlPkg::dataW-1:0] opA,
    output logic [pipeCtrlPkg::dataW-1:0] opB
);
    import pipeCtrlPkg::*;

    // five-way operand mux, one per decode source
    function automatic logic [dataW-1:0] pickOp(
        input fwdSel            sel,
        input logic [dataW-1:0] rf,
        input logic [dataW-1:0] e,
        input logic [dataW-1:0] m,
        input logic [dataW-1:0] m2,
        input logic [dataW-1:0] w
    );
        logic [dataW-1:0] val;
        case (sel)
            fwdE:    val = e;
            fwdM:    val = m;
            fwdM2:   val = m2;
            fwdW:    val = w;
            default: val = rf;  // fwdNone
        endcase
        return val;
    endfunction

    assign opA = pickOp(forward1D, rfData1, resultE, resultM, resultM2, resultW);
    assign opB = pickOp(forward2D, rfData2, resultE, resultM, resultM2, resultW);

    selLegal1: assert final (forward1D inside {fwdNone, fwdW, fwdM2, fwdM, fwdE})
        else $error("operandBypass: illegal forward1D %b", forward1D);
    selLegal2: assert final (forward2D inside {fwdNone, fwdW, fwdM2, fwdM, fwdE})
        else $error("operandBypass: illegal forward2D %b", forward2D);

endmodule

// ==== hw/pipeCtrlTop.sv ====
`timescale 1ns/1ps

module pipeCtrlTop (
    input  logic clk,
    input  logic rstN,
    input  logic [pipeCtrlPkg::regAddrW-1:0] rsD,
    input  logic [pipeCtrlPkg::regAddrW-1:0] rtD,
    input  logic [pipeCtrlPkg::regAddrW-1:0] writeRegD,
    input  logic regWriteD,
    input  pipeCtrlPkg::instKind kindD,
    input  logic [pipeCtrlPkg::dataW-1:0] resultD,
    input  logic iCacheStall,
    input  logic dCacheStall,
    input  logic aluStallE,
    input  logic jumpD,
    input  logic flushJumpConflictE,
    input  logic flushPredFailedM,
    input  logic flushExceptionM,
    output logic stallF,
    output logic stallF2,
    output logic stallD,
    output logic stallE,
    output logic stallM,
    output logic stallM2,
    output logic stallW,
    output logic flushF,
    output logic flushF2,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushM2,
    output logic flushW,
    output logic longestStall,
    output logic stallDBlank,
    output pipeCtrlPkg::fwdSel forward1D,
    output pipeCtrlPkg::fwdSel forward2D,
    output logic [pipeCtrlPkg::dataW-1:0] opA,
    output logic [pipeCtrlPkg::dataW-1:0] opB
);
    import pipeCtrlPkg::*;

    // tracked stage state from destTrack
    logic regWriteE, regWriteM, regWriteM2, regWriteW;
    logic [regAddrW-1:0] writeRegE, writeRegM, writeRegM2, writeRegW;
    logic [dataW-1:0] resultE, resultM, resultM2, resultW;
    logic memReadE, memReadM, isMfcE, hiloToRegE;
    logic [dataW-1:0] rfData1, rfData2;

    hazard u_hazard (.*);

    destTrack u_destTrack (.*);

    regFile u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWriteW && !stallW),  // held W does not write twice
        .waddr  (writeRegW),
        .wdata  (resultW),
        .raddr1 (rsD),
        .raddr2 (rtD),
        .rdata1 (rfData1),
        .rdata2 (rfData2)
    );

    operandBypass u_operandBypass (.*);

endmodule

// ==== bench/tbPipeCtrl.sv ====
`timescale 1ns/1ps

module tbPipeCtrl;
    import pipeCtrlPkg::*;

    localparam int numRandom = 400;
    localparam int stimCycles = 120 + 3 * numRandom;  // generous bound on stimulus length

    logic clk, rstN;
    logic [regAddrW-1:0] rsD, rtD, writeRegD;
    logic regWriteD;
    instKind kindD;
    logic [dataW-1:0] resultD;
    logic iCacheStall, dCacheStall, aluStallE, jumpD;
    logic flushJumpConflictE, flushPredFailedM, flushExceptionM;
    logic stallF, stallF2, stallD, stallE, stallM, stallM2, stallW;
    logic flushF, flushF2, flushD, flushE, flushM, flushM2, flushW;
    logic longestStall, stallDBlank;
    fwdSel forward1D, forward2D;
    logic [dataW-1:0] opA, opB;

    // reference model, index 0..3 is E, M, M2, W
    logic vld [4];
    logic [regAddrW-1:0] dst [4];
    instKind knd [4];
    logic [dataW-1:0] val [4];
    logic [dataW-1:0] arch [numRegs];
    logic [dataW-1:0] expA = '0, expB = '0;
    logic expLU = 1'b0, expLong = 1'b0, expStallD = 1'b0;
    logic accepted = 1'b0;
    logic [31:0] lfsr = 32'hf2a1;

    pipeCtrlTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("mismatch %s: expected %h, actual %h", name, exp, act);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] drawBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // newest in-flight writer of r, 4 when none
    function automatic int srcStage(input logic [regAddrW-1:0] r);
        if (r == '0) return 4;
        for (int s = 0; s < 4; s++) begin
            if (vld[s] && dst[s] == r) return s;
        end
        return 4;
    endfunction

    function automatic logic [dataW-1:0] expectOperand(input logic [regAddrW-1:0] r);
        int s;
        s = srcStage(r);
        if (r == '0) return '0;
        if (s < 4) return val[s];
        return arch[r];
    endfunction

    function automatic logic lateResult(input int s);
        return (s == 0 && knd[0] != kAlu) || (s == 1 && knd[1] == kLoad);
    endfunction

    always @(posedge clk) begin
        logic stallWm;
        if (!rstN) begin
            for (int s = 0; s < 4; s++) vld[s] = 1'b0;
            for (int r = 0; r < numRegs; r++) arch[r] = '0;
            accepted = 1'b0;
        end else begin
            stallWm = expLong && !flushExceptionM;
            if (vld[3] && !stallWm && dst[3] != '0) arch[dst[3]] = val[3];  // leaves W
            accepted = !expStallD;
            if (flushExceptionM) begin
                for (int s = 0; s < 4; s++) vld[s] = 1'b0;
            end else if (!expLong) begin
                for (int s = 3; s > 0; s--) begin
                    vld[s] = vld[s-1];
                    dst[s] = dst[s-1];
                    knd[s] = knd[s-1];
                    val[s] = val[s-1];
                end
                vld[0] = regWriteD && !flushPredFailedM && !expLU;  // bubble on flushE
                dst[0] = writeRegD;
                knd[0] = kindD;
                val[0] = resultD;
            end
        end
        #20;  // inputs have settled by now
        expLong   = iCacheStall || dCacheStall || aluStallE;
        expLU     = (lateResult(srcStage(rsD)) || lateResult(srcStage(rtD))) && !flushExceptionM;
        expStallD = expLong || expLU;
        expA      = expectOperand(rsD);
        expB      = expectOperand(rtD);
    end

    operandA: assert property (@(negedge clk) disable iff (!rstN) !expStallD |-> opA == expA)
        else reportMismatch("operandA", expA, opA);
    operandB: assert property (@(negedge clk) disable iff (!rstN) !expStallD |-> opB == expB)
        else reportMismatch("operandB", expB, opB);
    loadUse: assert property (@(negedge clk) disable iff (!rstN) stallDBlank == expLU)
        else reportMismatch("stallDBlank", expLU, stallDBlank);
    loadUseHoldsD: assert property (@(negedge clk) disable iff (!rstN) expLU |-> stallD)
        else reportFailure("stallD low during a load-use hazard");
    longStall: assert property (@(negedge clk) disable iff (!rstN)
                                expLong |-> stallE && stallM && stallM2 && longestStall
                                && stallW == !flushExceptionM)
        else reportFailure("stages not held during a cache or ALU stall");
    exceptionFlush: assert property (@(negedge clk) disable iff (!rstN)
                                     flushExceptionM |-> flushF2 && flushD && flushE && flushM
                                     && flushM2 && flushW && !flushF)
        else reportFailure("exception did not flush every stage");
    predFlush: assert property (@(negedge clk) disable iff (!rstN)
                                flushPredFailedM |-> flushF2 && flushD)
        else reportFailure("misprediction did not flush F2 and D");
    predFlushE: assert property (@(negedge clk) disable iff (!rstN)
                                 (flushPredFailedM && !flushExceptionM) |-> flushE == !expLong)
        else reportMismatch("flushE", !expLong, flushE);
    jumpFlush: assert property (@(negedge clk) disable iff (!rstN)
                                (jumpD && !expStallD) |-> flushF2)
        else reportFailure("jump did not flush F2");
    resetQuiet: assert property (@(negedge clk) !rstN |-> !(stallF || stallF2 || stallD || stallE
                                 || stallM || stallM2 || stallW || flushF || flushF2 || flushD
                                 || flushE || flushM || flushM2 || flushW || longestStall
                                 || stallDBlank) && forward1D == fwdNone && forward2D == fwdNone)
        else reportFailure("control outputs active during reset");

    // present one instruction and wait until D takes it
    task automatic issue(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] wr,
                         input logic we, input instKind k, input logic [31:0] res);
        rsD = rs;
        rtD = rt;
        writeRegD = wr;
        regWriteD = we;
        kindD = k;
        resultD = res;
        do begin
            @(posedge clk);
            #5;
        end while (!accepted);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    initial begin
        #(real'(stimCycles * 4 + 100) * 100.0);
        $display("timeout: simulation did not finish in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r1, r2, r3, we, k, res, sb;
        rstN = 1'b0;
        // a writing instruction that matches its own sources sits in D during reset
        rsD = 5'd1;
        rtD = 5'd2;
        writeRegD = 5'd1;
        regWriteD = 1'b1;
        resultD = '0;
        kindD = kAlu;
        {iCacheStall, dCacheStall, aluStallE, jumpD} = '0;
        {flushJumpConflictE, flushPredFailedM, flushExceptionM} = '0;
        repeat (8) @(posedge clk);
        #5;
        rstN = 1'b1;

        // forwarding chain then load-use cases
        issue(0, 0, 1, 1, kAlu, 32'h11);
        issue(0, 0, 2, 1, kAlu, 32'h22);
        issue(1, 2, 4, 1, kAlu, 32'h44);
        issue(4, 1, 3, 1, kLoad, 32'h33);
        issue(3, 4, 5, 1, kAlu, 32'h55);
        issue(0, 0, 6, 1, kLoad, 32'h66);
        issue(0, 0, 7, 1, kAlu, 32'h77);
        issue(6, 7, 0, 0, kAlu, 0);
        issue(0, 0, 2, 1, kMfc, 32'hc0);
        issue(2, 0, 1, 1, kHilo, 32'hd0);
        issue(1, 2, 0, 0, kAlu, 0);

        // cache and alu stalls, one with an exception on top
        issue(0, 0, 3, 1, kAlu, 32'h303);
        dCacheStall = 1'b1;
        idle(3);
        flushExceptionM = 1'b1;
        idle(1);
        {dCacheStall, flushExceptionM} = '0;
        issue(3, 1, 4, 1, kAlu, 32'h404);
        aluStallE = 1'b1;
        idle(1);
        iCacheStall = 1'b1;
        idle(2);
        {aluStallE, iCacheStall} = '0;
        idle(1);

        // exception drops everything in flight
        issue(0, 0, 5, 1, kAlu, 32'h5a5);
        issue(5, 0, 6, 1, kAlu, 32'h6a6);
        flushExceptionM = 1'b1;
        idle(1);
        flushExceptionM = 1'b0;
        issue(5, 6, 0, 0, kAlu, 0);

        // misprediction with and without a stall, then a jump
        issue(0, 0, 7, 1, kAlu, 32'h7b7);
        flushPredFailedM = 1'b1;
        idle(1);
        iCacheStall = 1'b1;
        idle(1);
        {flushPredFailedM, iCacheStall} = '0;
        jumpD = 1'b1;
        flushJumpConflictE = 1'b1;
        issue(7, 0, 1, 1, kAlu, 32'h1c1);
        {jumpD, flushJumpConflictE} = '0;

        for (int i = 0; i < numRandom; i++) begin
            r1 = drawBits(3);
            r2 = drawBits(3);
            r3 = drawBits(3);
            we = drawBits(1);
            k = drawBits(2);
            res = drawBits(32);
            sb = drawBits(4);
            if (sb < 3) begin
                case (sb[1:0])
                    2'd0: dCacheStall = 1'b1;
                    2'd1: flushExceptionM = 1'b1;
                    default: flushPredFailedM = 1'b1;
                endcase
                idle(1);
                {dCacheStall, flushExceptionM, flushPredFailedM} = '0;
            end
            jumpD = (sb == 4'd7);
            issue(r1[4:0], r2[4:0], r3[4:0], we[0], instKind'(k[1:0]), res);
        end
        jumpD = 1'b0;
        idle(6);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/pipeCtrlPkg.sv
hw/hazard.sv
hw/destTrack.sv
hw/regFile.sv
hw/operandBypass.sv
hw/pipeCtrlTop.sv
bench/tbPipeCtrl.sv

// ==== Bender.yml ====
package:
  name: pipe_ctrl

dependencies: {}

sources:
  - hw/pipeCtrlPkg.sv
  - hw/hazard.sv
  - hw/destTrack.sv
  - hw/regFile.sv
  - hw/operandBypass.sv
  - hw/pipeCtrlTop.sv
  - target: test
    files:
      - bench/tbPipeCtrl.sv
